// ==== rtl/pixel_writer_pkg.sv ====
package pixel_writer_pkg;

	//////////////////////////////
	// Widths and types
	//////////////////////////////

	// Pixel column or row number
	localparam int COORD_W = 10;
	// One colour byte in 3-3-2 RGB
	localparam int PIXEL_W = 8;
	// Video memory bus address
	localparam int ADDR_W = 32;

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic [ADDR_W-1:0]  bus_addr_t;

	//////////////////////////////
	// Memory layout
	//////////////////////////////

	// Upper-left pixel of the frame buffer
	localparam bus_addr_t VIDEO_BASE = 32'h0800_0000;
	// Row stride of 1024 bytes
	localparam int ROW_SHIFT = 10;

	//////////////////////////////
	// Test pattern
	//////////////////////////////

	// Rows below this are solid blue
	localparam coord_t BLUE_BAND_ROWS = 10'd50;
	// Rows below this carry the moving ramp
	localparam coord_t RAMP_BAND_ROWS = 10'd100;

	localparam pixel_t COLOR_BLUE  = 8'h03;
	localparam pixel_t COLOR_GREEN = 8'h1c;
	localparam pixel_t COLOR_BLACK = 8'h00;

	// Free-running frame timer
	localparam int TIMER_W = 30;
	// Lowest timer bit of the 8-bit ramp slice
	localparam int RAMP_SHIFT = 22;

endpackage

// ==== rtl/sync_gap_detect.sv ====
module sync_gap_detect #(
	parameter int VS_HOLD = 97000,
	parameter int HS_HOLD = 90
) (
	input  logic CLOCK2_50,
	input  logic rst_n,
	input  logic vga_vs,
	input  logic vga_hs,
	output logic write_window
);

	// Registered sync levels, bit 0 vsync and bit 1 hsync
	logic [1:0] sync_q;
	// Hold time still running after a rising edge
	logic [1:0] sync_wait;

	//////////////////////////////
	// Input register
	//////////////////////////////

	// Idle bus level is high for both syncs
	always_ff @(posedge CLOCK2_50 or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {vga_hs, vga_vs};
		end
	end

	//////////////////////////////
	// Hold counters
	//////////////////////////////

	// One counter per sync line
	for (genvar g = 0; g < 2; g++) begin : g_hold
		// Hold length of this line
		localparam int HOLD = (g == 0) ? VS_HOLD : HS_HOLD;
		localparam int CNT_W = $clog2(HOLD + 1);

		// Cycles since the sync rose, saturating at HOLD
		logic [CNT_W-1:0] hold_cnt;

		always_ff @(posedge CLOCK2_50 or negedge rst_n) begin
			if (!rst_n) begin
				// Start expired so no window right after reset
				hold_cnt <= CNT_W'(HOLD);
			end else if (!sync_q[g]) begin
				// Armed while low
				// Rising edge then starts the count at zero
				hold_cnt <= '0;
			end else if (hold_cnt != CNT_W'(HOLD)) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end

		// Wait flag until the hold time has passed
		assign sync_wait[g] = (hold_cnt != CNT_W'(HOLD));
	end

	//////////////////////////////
	// Write window
	//////////////////////////////

	// Either sync low, or either back porch hold running
	assign write_window = !sync_q[0] || !sync_q[1] || (|sync_wait);

endmodule

// ==== rtl/pixel_scanner.sv ====
module pixel_scanner import pixel_writer_pkg::*; #(
	parameter int FRAME_WIDTH = 640,
	parameter int SCAN_ROWS   = 400
) (
	input  logic   CLOCK2_50,
	input  logic   rst_n,
	input  logic   advance,
	output coord_t x,
	output coord_t y,
	output pixel_t pixel
);

	// Last column and row of the scan
	localparam coord_t X_LAST = coord_t'(FRAME_WIDTH - 1);
	localparam coord_t Y_LAST = coord_t'(SCAN_ROWS - 1);

	// Frame timer drives the ramp animation
	logic [TIMER_W-1:0] timer;
	// Column low byte plus timer slice
	pixel_t ramp;

	//////////////////////////////
	// Frame timer
	//////////////////////////////

	always_ff @(posedge CLOCK2_50 or negedge rst_n) begin
		if (!rst_n) begin
			timer <= '0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	//////////////////////////////
	// Coordinate scan
	//////////////////////////////

	// Row-major order, one step per accepted write
	always_ff @(posedge CLOCK2_50 or negedge rst_n) begin
		if (!rst_n) begin
			x <= '0;
			y <= '0;
		end else if (advance) begin
			if (x == X_LAST) begin
				// End of row
				x <= '0;
				if (y == Y_LAST) begin
					// End of frame
					y <= '0;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Colour pattern
	//////////////////////////////

	// Ramp wraps every 256 columns
	assign ramp = x[PIXEL_W-1:0] + timer[RAMP_SHIFT +: PIXEL_W];

	// Blue band, then ramp band, then green diagonal
	always_comb begin
		if (y < BLUE_BAND_ROWS) begin
			pixel = COLOR_BLUE;
		end else if (y < RAMP_BAND_ROWS) begin
			pixel = ramp;
		end else if (x == y) begin
			pixel = COLOR_GREEN;
		end else begin
			pixel = COLOR_BLACK;
		end
	end

	// Coordinate never leaves the visible frame
	a_coord_in_frame: assert property (@(posedge CLOCK2_50) disable iff (!rst_n)
		(x < FRAME_WIDTH) && (y < SCAN_ROWS))
		else $error("scan coordinate out of frame x=%0d y=%0d", x, y);

endmodule

// ==== rtl/bus_write_master.sv ====
module bus_write_master import pixel_writer_pkg::*; (
	input  logic      CLOCK2_50,
	input  logic      rst_n,
	input  logic      write_window,
	input  coord_t    x,
	input  coord_t    y,
	input  pixel_t    pixel,
	input  logic      bus_ack,
	output logic      advance,
	output logic      bus_write,
	output bus_addr_t bus_addr,
	output pixel_t    bus_write_data
);

	// Idle, or one write outstanding
	typedef enum logic {
		ST_IDLE,
		ST_WAIT_ACK
	} state_t;

	state_t    state;
	// Byte address of the current coordinate
	bus_addr_t pixel_addr;

	//////////////////////////////
	// Address calculation
	//////////////////////////////

	// Base plus column plus row times stride
	assign pixel_addr = VIDEO_BASE + bus_addr_t'(x) + (bus_addr_t'(y) << ROW_SHIFT);

	//////////////////////////////
	// Issue control
	//////////////////////////////

	// Issue when idle inside the window
	// Scanner steps on the same edge that captures the pixel
	assign advance = (state == ST_IDLE) && write_window;

	always_ff @(posedge CLOCK2_50 or negedge rst_n) begin
		if (!rst_n) begin
			state          <= ST_IDLE;
			bus_write      <= 1'b0;
			bus_addr       <= '0;
			bus_write_data <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (advance) begin
						// Address and data from one coordinate
						bus_addr       <= pixel_addr;
						bus_write_data <= pixel;
						bus_write      <= 1'b1;
						state          <= ST_WAIT_ACK;
					end
				end
				ST_WAIT_ACK: begin
					// Hold everything until the slave acknowledges
					if (bus_ack) begin
						bus_write <= 1'b0;
						state     <= ST_IDLE;
					end
				end
				default: begin
					bus_write <= 1'b0;
					state     <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// Protocol checks
	//////////////////////////////

	// Write request and payload held under back-pressure
	a_hold_until_ack: assert property (@(posedge CLOCK2_50) disable iff (!rst_n)
		bus_write && !bus_ack |=> bus_write && $stable(bus_addr) && $stable(bus_write_data))
		else $error("write request changed before acknowledge");

	// Scanner never moves with a write still in flight
	a_single_write: assert property (@(posedge CLOCK2_50) disable iff (!rst_n)
		!(advance && bus_write))
		else $error("advance raised while a write is outstanding");

endmodule

// ==== rtl/hex_digit_display.sv ====
module hex_digit_display import pixel_writer_pkg::*; (
	input  coord_t     row,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2
);

	//////////////////////////////
	// Segment decode
	//////////////////////////////

	// Active-low segments, a in bit 0 through g in bit 6
	function automatic logic [6:0] seg_decode(input logic [3:0] digit);
		logic [6:0] seg;
		case (digit)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h10;
			// Letters A to F
			4'ha: seg = 7'h08;
			4'hb: seg = 7'h03;
			4'hc: seg = 7'h46;
			4'hd: seg = 7'h21;
			4'he: seg = 7'h06;
			default: seg = 7'h0e;
		endcase
		return seg;
	endfunction

	//////////////////////////////
	// Digit select
	//////////////////////////////

	// Low nibble of the row
	assign hex0 = seg_decode(row[3:0]);
	// Middle nibble
	assign hex1 = seg_decode(row[7:4]);
	// Top digit has only the two upper row bits
	assign hex2 = seg_decode({2'b00, row[9:8]});

endmodule

// ==== rtl/pixel_writer_top.sv ====
module pixel_writer_top import pixel_writer_pkg::*; #(
	parameter int FRAME_WIDTH = 640,
	parameter int SCAN_ROWS   = 400,
	parameter int VS_HOLD     = 97000,
	parameter int HS_HOLD     = 90
) (
	input  logic       CLOCK2_50,
	input  logic       rst_n,
	input  logic       vga_vs,
	input  logic       vga_hs,
	input  logic       bus_ack,
	output logic       bus_write,
	output bus_addr_t  bus_addr,
	output pixel_t     bus_write_data,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2
);

	// Safe to write video memory
	logic   write_window;
	// Write accepted, step the scan
	logic   advance;
	// Current scan coordinate and its colour
	coord_t x;
	coord_t y;
	pixel_t pixel;

	//////////////////////////////
	// Sync gap detection
	//////////////////////////////

	sync_gap_detect #(
		.VS_HOLD (VS_HOLD),
		.HS_HOLD (HS_HOLD)
	) u_sync_gap_detect (
		.CLOCK2_50    (CLOCK2_50),
		.rst_n        (rst_n),
		.vga_vs       (vga_vs),
		.vga_hs       (vga_hs),
		.write_window (write_window)
	);

	//////////////////////////////
	// Scan and pattern
	//////////////////////////////

	pixel_scanner #(
		.FRAME_WIDTH (FRAME_WIDTH),
		.SCAN_ROWS   (SCAN_ROWS)
	) u_pixel_scanner (
		.CLOCK2_50 (CLOCK2_50),
		.rst_n     (rst_n),
		.advance   (advance),
		.x         (x),
		.y         (y),
		.pixel     (pixel)
	);

	//////////////////////////////
	// Bus master
	//////////////////////////////

	bus_write_master u_bus_write_master (
		.CLOCK2_50      (CLOCK2_50),
		.rst_n          (rst_n),
		.write_window   (write_window),
		.x              (x),
		.y              (y),
		.pixel          (pixel),
		.bus_ack        (bus_ack),
		.advance        (advance),
		.bus_write      (bus_write),
		.bus_addr       (bus_addr),
		.bus_write_data (bus_write_data)
	);

	// Row number on three digits
	hex_digit_display u_hex_digit_display (
		.row  (y),
		.hex0 (hex0),
		.hex1 (hex1),
		.hex2 (hex2)
	);

endmodule

// ==== include/pixel_writer_tb_tasks.svh ====
`ifndef PIXEL_WRITER_TB_TASKS_SVH
`define PIXEL_WRITER_TB_TASKS_SVH

//////////////////////////////
// Checks and stimulus helpers
//////////////////////////////

// Compare one value and count the mismatch
task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (actual !== expected) begin
		$display("mismatch %s expected %0h actual %0h", test_name, expected, actual);
		error_count++;
	end
endtask

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] state);
	logic [31:0] s;
	s = state;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// Lit segments as g down to a, inverted for the active-low pins
function automatic logic [6:0] segment_code(input logic [3:0] digit);
	logic [6:0] lit;
	case (digit)
		4'h0: lit = 7'b0111111;
		4'h1: lit = 7'b0000110;
		4'h2: lit = 7'b1011011;
		4'h3: lit = 7'b1001111;
		4'h4: lit = 7'b1100110;
		4'h5: lit = 7'b1101101;
		4'h6: lit = 7'b1111101;
		4'h7: lit = 7'b0000111;
		4'h8: lit = 7'b1111111;
		4'h9: lit = 7'b1101111;
		4'ha: lit = 7'b1110111;
		4'hb: lit = 7'b1111100;
		4'hc: lit = 7'b0111001;
		4'hd: lit = 7'b1011110;
		4'he: lit = 7'b1111001;
		default: lit = 7'b1110001;
	endcase
	return ~lit;
endfunction

// Ack pulse 0 to 3 cycles after the write is seen, or after a fixed delay
task automatic respond_write(input int fixed_delay);
	int delay;
	if (fixed_delay < 0) begin
		rng_state = xorshift32(rng_state);
		delay = int'(rng_state[1:0]);
	end else begin
		delay = fixed_delay;
	end
	repeat (delay) next_cycle();
	bus_ack = 1'b1;
	next_cycle();
	bus_ack = 1'b0;
endtask

`endif

// ==== test/tb_pixel_writer.sv ====
module tb_pixel_writer import pixel_writer_pkg::*; ();

	localparam int FRAME_WIDTH  = 8;
	localparam int SCAN_ROWS    = 120;
	localparam int VS_HOLD      = 20;
	localparam int HS_HOLD      = 4;
	localparam int FRAME_WRITES = FRAME_WIDTH * SCAN_ROWS;
	// About 2100 writes at up to five cycles each, doubled
	localparam int TIMEOUT_CYCLES = 20000;

	logic       CLOCK2_50;
	logic       rst_n;
	logic       vga_vs;
	logic       vga_hs;
	logic       bus_ack;
	logic       bus_write;
	bus_addr_t  bus_addr;
	pixel_t     bus_write_data;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;

	int          error_count;
	int          pass_count;
	int          fail_count;
	int          cycle_count;
	logic [31:0] rng_state;
	// Next coordinate the DUT should write
	int          exp_x;
	int          exp_y;

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge CLOCK2_50);
		#1;
	endtask

`include "pixel_writer_tb_tasks.svh"

	always #4 CLOCK2_50 = ~CLOCK2_50;

	pixel_writer_top #(
		.FRAME_WIDTH (FRAME_WIDTH),
		.SCAN_ROWS   (SCAN_ROWS),
		.VS_HOLD     (VS_HOLD),
		.HS_HOLD     (HS_HOLD)
	) DUT (
		.CLOCK2_50      (CLOCK2_50),
		.rst_n          (rst_n),
		.vga_vs         (vga_vs),
		.vga_hs         (vga_hs),
		.bus_ack        (bus_ack),
		.bus_write      (bus_write),
		.bus_addr       (bus_addr),
		.bus_write_data (bus_write_data),
		.hex0           (hex0),
		.hex1           (hex1),
		.hex2           (hex2)
	);

	// Run limit
	always @(posedge CLOCK2_50) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped writing", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Row stride of 2^ROW_SHIFT bytes
	function automatic bus_addr_t expected_addr(input int col, input int row);
		return VIDEO_BASE + bus_addr_t'(col) + bus_addr_t'(row) * (32'd1 << ROW_SHIFT);
	endfunction

	// Timer slice is still zero, ramp is the column byte alone
	function automatic pixel_t expected_pixel(input int col, input int row);
		if (row < BLUE_BAND_ROWS) return COLOR_BLUE;
		if (row < RAMP_BAND_ROWS) return pixel_t'(col % 256);
		if (col == row) return COLOR_GREEN;
		return COLOR_BLACK;
	endfunction

	// Check the write just issued, then step the expected scan
	task automatic check_write(input string name);
		check_value({name, " addr"}, expected_addr(exp_x, exp_y), bus_addr);
		check_value({name, " data"}, expected_pixel(exp_x, exp_y), bus_write_data);
		exp_x++;
		if (exp_x == FRAME_WIDTH) begin
			exp_x = 0;
			exp_y = (exp_y + 1) % SCAN_ROWS;
		end
		// Scanner already moved on
		check_value({name, " hex0"}, segment_code(exp_y[3:0]), hex0);
		check_value({name, " hex1"}, segment_code(exp_y[7:4]), hex1);
		check_value({name, " hex2"}, segment_code({2'b00, exp_y[9:8]}), hex2);
	endtask

	task automatic take_write(input string name);
		while (bus_write !== 1'b1) next_cycle();
		check_write(name);
		respond_write(-1);
	endtask

	task automatic finish_test(input string name, input int errors_at_start);
		if (error_count == errors_at_start) begin
			$display("test %s passed", name);
			pass_count++;
		end else begin
			$display("test %s failed with %0d errors", name, error_count - errors_at_start);
			fail_count++;
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_reset();
		int start;
		start = error_count;
		repeat (4) begin
			next_cycle();
			check_value("reset write", 0, bus_write);
			check_value("reset hex0", segment_code(4'h0), hex0);
			check_value("reset hex1", segment_code(4'h0), hex1);
			check_value("reset hex2", segment_code(4'h0), hex2);
		end
		rst_n = 1'b1;
		// Both syncs high, window closed
		repeat (8) begin
			next_cycle();
			check_value("reset write", 0, bus_write);
		end
		finish_test("reset", start);
	endtask

	task automatic test_address_wrap();
		int start;
		start = error_count;
		vga_vs = 1'b0;
		// Full frame plus one row past the wrap
		repeat (FRAME_WRITES + FRAME_WIDTH) take_write("address_wrap");
		finish_test("address_wrap", start);
	endtask

	task automatic test_colour();
		int start;
		start = error_count;
		repeat (FRAME_WRITES) take_write("colour");
		finish_test("colour", start);
	endtask

	task automatic test_backpressure();
		int        start;
		bus_addr_t held_addr;
		pixel_t    held_data;
		start = error_count;
		while (bus_write !== 1'b1) next_cycle();
		// Reference values of the stalled write
		held_addr = expected_addr(exp_x, exp_y);
		held_data = expected_pixel(exp_x, exp_y);
		check_write("backpressure");
		repeat (30) begin
			next_cycle();
			check_value("backpressure write", 1, bus_write);
			check_value("backpressure addr", held_addr, bus_addr);
			check_value("backpressure data", held_data, bus_write_data);
		end
		respond_write(0);
		repeat (4) take_write("backpressure");
		finish_test("backpressure", start);
	endtask

	task automatic test_write_window();
		int start;
		int i;
		int waited;
		start = error_count;
		vga_vs = 1'b1;
		vga_hs = 1'b1;
		// Drain writes still inside the hold time
		for (i = 0; i < VS_HOLD + 4; i++) begin
			next_cycle();
			if (bus_write === 1'b1) begin
				check_write("write_window");
				respond_write(-1);
			end
		end
		repeat (20) begin
			next_cycle();
			check_value("write_window closed", 0, bus_write);
		end
		vga_hs = 1'b0;
		waited = 0;
		while (bus_write !== 1'b1 && waited < 8) begin
			next_cycle();
			waited++;
		end
		if (bus_write !== 1'b1) begin
			$display("write_window: no write resumed within 8 cycles after hsync went low");
			error_count++;
		end else begin
			check_write("write_window");
			respond_write(-1);
		end
		repeat (4) take_write("write_window");
		finish_test("write_window", start);
	endtask

	task automatic test_row_display();
		int start;
		start = error_count;
		vga_vs = 1'b0;
		vga_hs = 1'b1;
		// Enough rows to roll the middle digit
		repeat (FRAME_WIDTH * 17) take_write("row_display");
		finish_test("row_display", start);
	endtask

	initial begin
		CLOCK2_50   = 1'b0;
		rst_n       = 1'b0;
		vga_vs      = 1'b1;
		vga_hs      = 1'b1;
		bus_ack     = 1'b0;
		error_count = 0;
		pass_count  = 0;
		fail_count  = 0;
		cycle_count = 0;
		rng_state   = 32'ha13c441d;
		exp_x       = 0;
		exp_y       = 0;
		test_reset();
		test_address_wrap();
		test_colour();
		test_backpressure();
		test_write_window();
		test_row_display();
		$display("tests passed %0d failed %0d, check errors %0d",
			pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
rtl/pixel_writer_pkg.sv
rtl/sync_gap_detect.sv
rtl/pixel_scanner.sv
rtl/bus_write_master.sv
rtl/hex_digit_display.sv
rtl/pixel_writer_top.sv
test/tb_pixel_writer.sv

// ==== Bender.yml ====
package:
  name: pixel_writer

export_include_dirs:
  - include

sources:
  - files:
      - rtl/pixel_writer_pkg.sv
      - rtl/sync_gap_detect.sv
      - rtl/pixel_scanner.sv
      - rtl/bus_write_master.sv
      - rtl/hex_digit_display.sv
      - rtl/pixel_writer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_pixel_writer.sv
